//--- files.f
+incdir+include
rtl/tcb_pkg.sv
rtl/tcb_dly.sv
rtl/tcb_dec.sv
rtl/tcb_mem_sub.sv
rtl/tcb_reg_sub.sv
rtl/tcb_rsp_mux.sv
rtl/tcb_subsys.sv
dv/tcb_subsys_tb.sv

//--- include/tcb_tb_vectors.svh
// tcb cluster testbench vector table, requests with their expected responses
`ifndef TCB_TB_VECTORS_SVH
`define TCB_TB_VECTORS_SVH

// one slot per table entry
string              vec_name [$];
logic               vec_wen  [$];
logic [tcb_abw-1:0] vec_adr  [$];
logic [tcb_bew-1:0] vec_ben  [$];
logic [tcb_dbw-1:0] vec_wdt  [$];
logic [tcb_dbw-1:0] vec_rdt  [$];
logic               vec_err  [$];
// entry follows the previous one with no idle cycle
logic               vec_b2b  [$];

task automatic add_vec(input string name, input logic wen, input logic [tcb_abw-1:0] adr,
                       input logic [tcb_bew-1:0] ben, input logic [tcb_dbw-1:0] wdt,
                       input logic [tcb_dbw-1:0] rdt, input logic err, input logic b2b);
  vec_name.push_back(name);
  vec_wen.push_back(wen);
  vec_adr.push_back(adr);
  vec_ben.push_back(ben);
  vec_wdt.push_back(wdt);
  vec_rdt.push_back(rdt);
  vec_err.push_back(err);
  vec_b2b.push_back(b2b);
endtask

task automatic load_vectors();
  // name, wen, adr, ben, wdt, expected rdt, expected err, back-to-back
  // memory write then read, partly back-to-back
  add_vec("mem_wr0",      1'b1, 16'h0000, 4'hf, 32'h1122_3344, 32'h0000_0000, 1'b0, 1'b0);
  add_vec("mem_wr1",      1'b1, 16'h0004, 4'hf, 32'hA5A5_5A5A, 32'h0000_0000, 1'b0, 1'b1);
  add_vec("mem_rd0",      1'b0, 16'h0000, 4'hf, 32'h0000_0000, 32'h1122_3344, 1'b0, 1'b1);
  add_vec("mem_rd1",      1'b0, 16'h0004, 4'hf, 32'h0000_0000, 32'hA5A5_5A5A, 1'b0, 1'b1);
  add_vec("mem_wr_top",   1'b1, 16'h03FC, 4'hf, 32'hDEAD_BEEF, 32'h0000_0000, 1'b0, 1'b0);
  add_vec("mem_rd_top",   1'b0, 16'h03FC, 4'hf, 32'h0000_0000, 32'hDEAD_BEEF, 1'b0, 1'b1);
  // partial byte enables on words written above
  add_vec("mem_be_wr0",   1'b1, 16'h0000, 4'h5, 32'hAABB_CCDD, 32'h0000_0000, 1'b0, 1'b0);
  add_vec("mem_be_rd0",   1'b0, 16'h0000, 4'hf, 32'h0000_0000, 32'h11BB_33DD, 1'b0, 1'b1);
  add_vec("mem_be_wr1",   1'b1, 16'h0004, 4'h8, 32'h7700_0000, 32'h0000_0000, 1'b0, 1'b0);
  add_vec("mem_be_rd1",   1'b0, 16'h0004, 4'hf, 32'h0000_0000, 32'h77A5_5A5A, 1'b0, 1'b0);
  // register bank, identity and scratch
  add_vec("reg_id_rd",    1'b0, 16'h8008, 4'hf, 32'h0000_0000, 32'h7CB0_0001, 1'b0, 1'b0);
  add_vec("reg_cnt_rd0",  1'b0, 16'h800C, 4'hf, 32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
  add_vec("reg_scr0_wr",  1'b1, 16'h8000, 4'hf, 32'hCAFE_F00D, 32'h0000_0000, 1'b0, 1'b0);
  add_vec("reg_scr1_wr",  1'b1, 16'h8004, 4'h3, 32'h1234_5678, 32'h0000_0000, 1'b0, 1'b0);
  add_vec("reg_scr0_rd",  1'b0, 16'h8000, 4'hf, 32'h0000_0000, 32'hCAFE_F00D, 1'b0, 1'b1);
  add_vec("reg_scr1_rd",  1'b0, 16'h8004, 4'hf, 32'h0000_0000, 32'h0000_5678, 1'b0, 1'b1);
  add_vec("reg_scr0_bwr", 1'b1, 16'h8000, 4'hc, 32'h5566_0000, 32'h0000_0000, 1'b0, 1'b0);
  add_vec("reg_scr0_brd", 1'b0, 16'h8000, 4'hf, 32'h0000_0000, 32'h5566_F00D, 1'b0, 1'b0);
  // three good scratch writes so far
  add_vec("reg_cnt_rd1",  1'b0, 16'h800C, 4'hf, 32'h0000_0000, 32'h0000_0003, 1'b0, 1'b0);
  // error cases, none of them may change state
  add_vec("reg_id_wr",    1'b1, 16'h8008, 4'hf, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1, 1'b0);
  add_vec("reg_cnt_wr",   1'b1, 16'h800C, 4'hf, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1, 1'b0);
  add_vec("reg_oor_rd",   1'b0, 16'h8010, 4'hf, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
  add_vec("reg_oor_wr",   1'b1, 16'h8010, 4'hf, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1, 1'b0);
  add_vec("reg_mis_rd",   1'b0, 16'h8001, 4'hf, 32'h0000_0000, 32'h0000_0000, 1'b1, 1'b0);
  add_vec("reg_mis_wr",   1'b1, 16'h8006, 4'hf, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1, 1'b0);
  add_vec("reg_scr0_chk", 1'b0, 16'h8000, 4'hf, 32'h0000_0000, 32'h5566_F00D, 1'b0, 1'b0);
  add_vec("reg_scr1_chk", 1'b0, 16'h8004, 4'hf, 32'h0000_0000, 32'h0000_5678, 1'b0, 1'b0);
  add_vec("reg_cnt_chk",  1'b0, 16'h800C, 4'hf, 32'h0000_0000, 32'h0000_0003, 1'b0, 1'b0);
  // alternate subordinates every cycle
  add_vec("alt_mem_rd0",  1'b0, 16'h0000, 4'hf, 32'h0000_0000, 32'h11BB_33DD, 1'b0, 1'b0);
  add_vec("alt_reg_id",   1'b0, 16'h8008, 4'hf, 32'h0000_0000, 32'h7CB0_0001, 1'b0, 1'b1);
  add_vec("alt_mem_rd1",  1'b0, 16'h0004, 4'hf, 32'h0000_0000, 32'h77A5_5A5A, 1'b0, 1'b1);
  add_vec("alt_reg_scr1", 1'b0, 16'h8004, 4'hf, 32'h0000_0000, 32'h0000_5678, 1'b0, 1'b1);
  add_vec("alt_mem_top",  1'b0, 16'h03FC, 4'hf, 32'h0000_0000, 32'hDEAD_BEEF, 1'b0, 1'b1);
  add_vec("alt_reg_cnt",  1'b0, 16'h800C, 4'hf, 32'h0000_0000, 32'h0000_0003, 1'b0, 1'b1);
endtask

`endif

//--- dv/tcb_subsys_tb.sv
// tcb subordinate cluster testbench, table-driven requests checked against expected responses
`timescale 1ns/1ps

module tcb_subsys_tb
  import tcb_pkg::*;
();

  localparam int unsigned dly    = 2;
  localparam int unsigned mem_aw = 8;

  logic     tcb;
  logic     rst_n;
  logic     req_vld;
  tcb_req_t req;
  logic     req_rdy;
  tcb_rsp_t rsp;

  // table entry currently on the bus
  int       cur_idx;
  // due negedge and table index of each accepted request
  int       due_q [$];
  int       idx_q [$];
  int       neg_cnt;
  int       cyc_cnt;
  int       tmo_lim;
  int       pass_cnt;
  int       fail_cnt;
  int       chk_idx;
  logic [7:0] lfsr;

  `include "tcb_tb_vectors.svh"

  tcb_subsys #(
    .DLY    (dly),
    .MEM_AW (mem_aw)
  ) tcb_subsys_inst (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req     (req),
    .req_rdy (req_rdy),
    .rsp     (rsp)
  );

  initial begin
    tcb = 1'b0;
    forever #10 tcb = ~tcb;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // 8-bit fibonacci, taps 8 6 5 4
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    logic fb;
    fb = s[7] ^ s[5] ^ s[4] ^ s[3];
    return {s[6:0], fb};
  endfunction

  task automatic check_rsp(input int k);
    assert (rsp.rdt === vec_rdt[k] && rsp.err === vec_err[k]) begin
      pass_cnt++;
      $display("ok     %s rdt=%h err=%b", vec_name[k], rsp.rdt, rsp.err);
    end else begin
      fail_cnt++;
      $display("FAILED %s expected rdt=%h err=%b actual rdt=%h err=%b",
               vec_name[k], vec_rdt[k], vec_err[k], rsp.rdt, rsp.err);
    end
  endtask

  //////////////////////////////
  // driver
  //////////////////////////////

  initial begin : drive
    logic [1:0] idle;
    int         n;
    rst_n    = 1'b0;
    req_vld  = 1'b0;
    req      = '0;
    cur_idx  = 0;
    lfsr     = 8'd59;
    pass_cnt = 0;
    fail_cnt = 0;
    load_vectors();
    n        = vec_name.size();
    // worst case 3 idles plus the transfer per entry
    tmo_lim  = n * 4 + dly + 20;
    repeat (2) @(posedge tcb);
    // ready and response must be clear while in reset
    @(negedge tcb);
    assert (req_rdy === 1'b0 && rsp === '0) begin
      pass_cnt++;
      $display("ok     reset_state");
    end else begin
      fail_cnt++;
      $display("ready or response not cleared during reset");
    end
    @(posedge tcb);
    rst_n <= 1'b1;
    for (int i = 0; i < n; i++) begin
      // two lfsr bits give 0..3 idle cycles
      lfsr    = lfsr_step(lfsr);
      idle[0] = lfsr[0];
      lfsr    = lfsr_step(lfsr);
      idle[1] = lfsr[0];
      if (vec_b2b[i]) begin
        idle = 2'd0;
      end
      repeat (idle) begin
        @(posedge tcb);
        req_vld <= 1'b0;
      end
      @(posedge tcb);
      req_vld <= 1'b1;
      req.wen <= vec_wen[i];
      req.adr <= vec_adr[i];
      req.ben <= vec_ben[i];
      req.wdt <= vec_wdt[i];
      cur_idx = i;
      // hold until ready, transfer lands on the next edge
      @(negedge tcb);
      while (!req_rdy) begin
        @(negedge tcb);
      end
    end
    @(posedge tcb);
    req_vld <= 1'b0;
    // drain the responses still in flight
    while (pass_cnt + fail_cnt < n + 1 || due_q.size() > 0) begin
      @(negedge tcb);
    end
    $display("tests %0d passed %0d failed %0d", n + 1, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == n + 1) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  //////////////////////////////
  // response checker
  //////////////////////////////

  // negedge sampling, inputs and rsp are settled here
  always @(negedge tcb) begin
    if (rst_n) begin
      neg_cnt++;
      if (req_vld && req_rdy) begin
        due_q.push_back(neg_cnt + dly);
        idx_q.push_back(cur_idx);
      end
      if (due_q.size() > 0 && due_q[0] == neg_cnt) begin
        chk_idx = idx_q.pop_front();
        void'(due_q.pop_front());
        check_rsp(chk_idx);
      end else begin
        // nothing due, mux must output zero
        assert (rsp === '0) else begin
          fail_cnt++;
          $display("response not zero on a cycle with no transfer due");
        end
      end
    end
  end

  // hard limit on run length
  always @(posedge tcb) begin
    cyc_cnt++;
    if (cyc_cnt > tmo_lim) begin
      $display("timeout, run did not finish within %0d cycles", tmo_lim);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule : tcb_subsys_tb

//--- rtl/tcb_subsys.sv
// tcb subordinate cluster top, decoder, memory, register bank and response mux
`timescale 1ns/1ps

module tcb_subsys
  import tcb_pkg::*;
#(
  // response latency, 0 to 4
  parameter int unsigned DLY    = 2,
  // memory word address width
  parameter int unsigned MEM_AW = 8
) (
  input  logic     tcb,
  input  logic     rst_n,
  // manager port
  input  logic     req_vld,
  input  tcb_req_t req,
  output logic     req_rdy,
  output tcb_rsp_t rsp
);

  //////////////////////////////
  // internal wiring
  //////////////////////////////

  logic     mem_vld;
  logic     reg_vld;
  logic     mem_rdy;
  logic     reg_rdy;
  tcb_req_t sub_req;
  tcb_rsp_t mem_rsp;
  tcb_rsp_t reg_rsp;
  // routing info for the output side
  logic     sel;
  logic     trn;

  // input side
  tcb_dec tcb_dec_inst (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req     (req),
    .req_rdy (req_rdy),
    .mem_vld (mem_vld),
    .reg_vld (reg_vld),
    .sub_req (sub_req),
    .mem_rdy (mem_rdy),
    .reg_rdy (reg_rdy),
    .sel     (sel),
    .trn     (trn)
  );

  //////////////////////////////
  // subordinates
  //////////////////////////////

  tcb_mem_sub #(
    .DLY    (DLY),
    .MEM_AW (MEM_AW)
  ) tcb_mem_sub_inst (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (mem_vld),
    .req   (sub_req),
    .rdy   (mem_rdy),
    .rsp   (mem_rsp)
  );

  tcb_reg_sub #(
    .DLY (DLY)
  ) tcb_reg_sub_inst (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (reg_vld),
    .req   (sub_req),
    .rdy   (reg_rdy),
    .rsp   (reg_rsp)
  );

  // output side, keeps responses in request order
  tcb_rsp_mux #(
    .DLY (DLY)
  ) tcb_rsp_mux_inst (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .sel     (sel),
    .trn     (trn),
    .mem_rsp (mem_rsp),
    .reg_rsp (reg_rsp),
    .rsp     (rsp)
  );

endmodule : tcb_subsys

//--- rtl/tcb_rsp_mux.sv
// tcb response multiplexer, picks the subordinate addressed DLY cycles earlier
`timescale 1ns/1ps

module tcb_rsp_mux
  import tcb_pkg::*;
#(
  parameter int unsigned DLY = 2
) (
  input  logic     tcb,
  input  logic     rst_n,
  // routing info at request time
  input  logic     sel,
  input  logic     trn,
  // subordinate responses
  input  tcb_rsp_t mem_rsp,
  input  tcb_rsp_t reg_rsp,
  // to the manager
  output tcb_rsp_t rsp
);

  // select and transfer flag travel together
  typedef struct packed {
    logic sel;
    logic trn;
  } rte_t;

  rte_t rte_req;
  rte_t rte_rsp;

  assign rte_req = '{sel: sel, trn: trn};

  // select path, same latency as the subordinates
  tcb_dly #(
    .DLY       (DLY),
    .payload_t (rte_t)
  ) rte_dly_inst (
    .tcb   (tcb),
    .rst_n (rst_n),
    .din   (rte_req),
    .dout  (rte_rsp)
  );

  // data path is combinational
  // zero when nothing was accepted DLY cycles ago
  assign rsp = !rte_rsp.trn              ? '0      :
               (rte_rsp.sel == tcb_sel_reg) ? reg_rsp : mem_rsp;

endmodule : tcb_rsp_mux

//--- rtl/tcb_reg_sub.sv
// tcb register bank subordinate, scratch, identity and write-count registers
`timescale 1ns/1ps

module tcb_reg_sub
  import tcb_pkg::*;
#(
  // response latency in cycles
  parameter int unsigned DLY = 2
) (
  input  logic     tcb,
  input  logic     rst_n,
  input  logic     vld,
  input  tcb_req_t req,
  output logic     rdy,
  output tcb_rsp_t rsp
);

  //////////////////////////////
  // local signals
  //////////////////////////////

  logic               trn;
  // register offset inside the bank
  logic [11:0]        adr_off;
  // misaligned, out of range, read-only target
  logic               adr_mis;
  logic               adr_oor;
  logic               adr_ro;
  // request rejected with err
  logic               bad;
  // register index, 0..3
  logic [1:0]         idx;
  // successful scratch write
  logic               scr_wr;
  logic [tcb_dbw-1:0] scr [2];
  // counts scratch writes, wraps
  logic [tcb_dbw-1:0] cnt;
  tcb_rsp_t           tmp;

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  assign trn = vld && rdy;

  //////////////////////////////
  // offset decode
  //////////////////////////////

  assign adr_off = req.adr[11:0];
  assign adr_mis = |adr_off[1:0];
  assign adr_oor = adr_off > 12'hc;
  // identity and counter sit at 0x8 and 0xc
  assign adr_ro  = adr_off[3];
  assign bad     = adr_mis || adr_oor || (req.wen && adr_ro);
  assign idx     = adr_off[3:2];
  // good writes can only target the scratch pair
  assign scr_wr  = trn && req.wen && !bad;

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      scr[0] <= '0;
      scr[1] <= '0;
      cnt    <= '0;
    end else if (scr_wr) begin
      for (int b = 0; b < tcb_bew; b++) begin
        if (req.ben[b]) begin
          scr[idx[0]][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
      cnt <= cnt + 1'b1;
    end
  end

  //////////////////////////////
  // response
  //////////////////////////////

  // counter reads the value from before this request
  always_comb begin
    tmp = '0;
    if (trn) begin
      tmp.err = bad;
      if (!req.wen && !bad) begin
        case (idx)
          2'd0:    tmp.rdt = scr[0];
          2'd1:    tmp.rdt = scr[1];
          2'd2:    tmp.rdt = tcb_reg_id_val;
          default: tmp.rdt = cnt;
        endcase
      end
    end
  end

  tcb_dly #(
    .DLY       (DLY),
    .payload_t (tcb_rsp_t)
  ) rsp_dly_inst (
    .tcb   (tcb),
    .rst_n (rst_n),
    .din   (tmp),
    .dout  (rsp)
  );

endmodule : tcb_reg_sub

//--- rtl/tcb_mem_sub.sv
// tcb memory subordinate, word array with byte-enabled writes and pipelined read data
`timescale 1ns/1ps

module tcb_mem_sub
  import tcb_pkg::*;
#(
  // response latency in cycles
  parameter int unsigned DLY    = 2,
  // word address width
  parameter int unsigned MEM_AW = 8
) (
  input  logic     tcb,
  input  logic     rst_n,
  input  logic     vld,
  input  tcb_req_t req,
  output logic     rdy,
  output tcb_rsp_t rsp
);

  //////////////////////////////
  // local signals
  //////////////////////////////

  // local transfer strobe
  logic              trn;
  // word index, byte offset bits dropped
  logic [MEM_AW-1:0] idx;
  // response before the pipeline
  tcb_rsp_t          tmp;
  // storage
  logic [tcb_dbw-1:0] mem [2**MEM_AW];

  // always ready once out of reset
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  assign trn = vld && rdy;
  assign idx = req.adr[MEM_AW+1:2];

  //////////////////////////////
  // write port
  //////////////////////////////

  // only enabled bytes change, visible on the next cycle
  always_ff @(posedge tcb) begin
    if (trn && req.wen) begin
      for (int b = 0; b < tcb_bew; b++) begin
        if (req.ben[b]) begin
          mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // response
  //////////////////////////////

  // read returns stored word, writes and idle cycles return zero
  assign tmp.rdt = (trn && !req.wen) ? mem[idx] : '0;
  // never errors
  assign tmp.err = 1'b0;

  tcb_dly #(
    .DLY       (DLY),
    .payload_t (tcb_rsp_t)
  ) rsp_dly_inst (
    .tcb   (tcb),
    .rst_n (rst_n),
    .din   (tmp),
    .dout  (rsp)
  );

endmodule : tcb_mem_sub

//--- rtl/tcb_dec.sv
// tcb address decoder, routes the manager request to memory or register bank
`timescale 1ns/1ps

module tcb_dec
  import tcb_pkg::*;
(
  // clock and reset, decode itself has no state
  input  logic     tcb,
  input  logic     rst_n,
  // manager side
  input  logic     req_vld,
  input  tcb_req_t req,
  output logic     req_rdy,
  // subordinate valids
  output logic     mem_vld,
  output logic     reg_vld,
  // request shared by both subordinates
  output tcb_req_t sub_req,
  // subordinate readies
  input  logic     mem_rdy,
  input  logic     reg_rdy,
  // routing info for the response mux
  output logic     sel,
  output logic     trn
);

  //////////////////////////////
  // address decode
  //////////////////////////////

  // top address bit picks the subordinate
  assign sel = req.adr[tcb_abw-1];

  //////////////////////////////
  // valid steering
  //////////////////////////////

  // only the addressed subordinate sees valid
  assign mem_vld = req_vld && (sel == tcb_sel_mem);
  assign reg_vld = req_vld && (sel == tcb_sel_reg);

  // payload fans out unchanged, valid does the routing
  assign sub_req = req;

  //////////////////////////////
  // ready return
  //////////////////////////////

  // ready mirrors the addressed subordinate
  // no back-pressure is added here
  assign req_rdy = (sel == tcb_sel_reg) ? reg_rdy : mem_rdy;

  // accepted transfer, goes with sel to the response side
  assign trn = req_vld && req_rdy;

  // tcb and rst_n reach this level only for a uniform port list
  // the decode is purely combinational

endmodule : tcb_dec

//--- rtl/tcb_dly.sv
// tcb response pipeline, fixed-length delay line for any payload type
`timescale 1ns/1ps

module tcb_dly #(
  // number of stages, 0 gives a plain wire
  parameter int unsigned DLY = 2,
  // payload carried through the stages
  parameter type payload_t = logic
) (
  input  logic     tcb,
  input  logic     rst_n,
  input  payload_t din,
  output payload_t dout
);

  generate
    if (DLY == 0) begin : g_wire
      // zero latency, response follows the request combinationally
      assign dout = din;
    end else begin : g_pipe
      // stage 0 takes din, last stage drives dout
      payload_t pip [DLY];

      // shifts every cycle, idle cycles push whatever din holds
      always_ff @(posedge tcb or negedge rst_n) begin
        if (!rst_n) begin
          for (int i = 0; i < DLY; i++) begin
            pip[i] <= '0;
          end
        end else begin
          pip[0] <= din;
          for (int i = 1; i < DLY; i++) begin
            pip[i] <= pip[i-1];
          end
        end
      end

      assign dout = pip[DLY-1];
    end
  endgenerate

endmodule : tcb_dly

//--- rtl/tcb_pkg.sv
// tcb subordinate cluster package, bus widths, address map and request/response structs

package tcb_pkg;

  //////////////////////////////
  // bus widths
  //////////////////////////////

  // address width in bits
  localparam int unsigned tcb_abw = 16;
  // data width in bits
  localparam int unsigned tcb_dbw = 32;
  // one enable per data byte
  localparam int unsigned tcb_bew = tcb_dbw / 8;

  //////////////////////////////
  // address map
  //////////////////////////////

  // routing select is address bit 15
  // lower half of the space goes to memory
  localparam logic tcb_sel_mem = 1'b0;
  // upper half goes to the register bank
  localparam logic tcb_sel_reg = 1'b1;

  // constant returned by the identity register
  localparam logic [tcb_dbw-1:0] tcb_reg_id_val = 32'h7CB0_0001;

  //////////////////////////////
  // request and response
  //////////////////////////////

  // request, 53 bits
  typedef struct packed {
    // write enable, low for read
    logic               wen;
    // byte address
    logic [tcb_abw-1:0] adr;
    // byte enables
    logic [tcb_bew-1:0] ben;
    // write data
    logic [tcb_dbw-1:0] wdt;
  } tcb_req_t;

  // response, 33 bits
  typedef struct packed {
    // read data
    logic [tcb_dbw-1:0] rdt;
    // error flag
    logic               err;
  } tcb_rsp_t;

endpackage : tcb_pkg
